//--- common/ghash_pkg.sv
package ghash_pkg;

    // Width of one GHASH block.
    localparam int NB_BLOCK = 128;

    // Stored key powers, H and H^2.
    localparam int N_POWERS = 2;

    // GCM reduction constant in reflected order.
    // Bit 127 of a block holds the x^0 coefficient.
    // The 0xE1 byte covers x^0, x^1, x^2 and x^7.
    localparam logic [NB_BLOCK-1:0] GF128_R = {8'hE1, 120'h0};

    // One input block as it enters the engine.
    typedef struct packed {
        logic [NB_BLOCK-1:0] data;
        // Final block of the message.
        logic                last;
    } ghash_block_t;

    // Two blocks folded in a single accumulator step.
    typedef struct packed {
        logic [NB_BLOCK-1:0] first;
        logic [NB_BLOCK-1:0] second;
        // Only the first block is meaningful.
        logic                single;
        // Pair closes the message.
        logic                last;
    } ghash_pair_t;

    // Key power table contents.
    typedef struct packed {
        logic [NB_BLOCK-1:0] h1;
        logic [NB_BLOCK-1:0] h2;
    } ghash_powers_t;

endpackage

//--- design/gf128_mult.sv
`timescale 1ns/1ns

module gf128_mult
(
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_data_x,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_data_y,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_data_z
);

    // Running product.
    logic [ghash_pkg::NB_BLOCK-1:0] z_acc;
    // Multiplicand, times x^i at step i.
    logic [ghash_pkg::NB_BLOCK-1:0] v_acc;

    // Shift-and-add product in GCM bit order.
    // Step i looks at the x^i coefficient of X, which is bit 127-i.
    // A right shift of V multiplies by x.
    // The bit shifted out of x^127 folds back through the constant.
    always_comb
    begin
        z_acc = '0;
        v_acc = i_data_y;
        for (int i = 0; i < ghash_pkg::NB_BLOCK; i++)
        begin
            // Add V when this coefficient of X is set.
            if (i_data_x[ghash_pkg::NB_BLOCK-1-i])
            begin
                z_acc = z_acc ^ v_acc;
            end
            // Multiply V by x, reducing on overflow.
            if (v_acc[0])
            begin
                v_acc = (v_acc >> 1) ^ ghash_pkg::GF128_R;
            end
            else
            begin
                v_acc = v_acc >> 1;
            end
        end
    end

    // Result is already reduced.
    assign o_data_z = z_acc;

endmodule

//--- h_key_power_table/h_key_power_table.sv
`timescale 1ns/1ns

module h_key_power_table
(
    input  logic                          i_clock,
    input  logic                          i_rst_n,
    input  logic                          i_key_load,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_h_key,
    output ghash_pkg::ghash_powers_t      o_powers,
    output logic                          o_key_ready
);

    // Square of the incoming key.
    logic [ghash_pkg::NB_BLOCK-1:0] h_sq;
    // Next powers, index k holds H^(k+1).
    logic [ghash_pkg::NB_BLOCK-1:0] pow_d [ghash_pkg::N_POWERS];
    // Stored powers.
    logic [ghash_pkg::NB_BLOCK-1:0] pow_q [ghash_pkg::N_POWERS];
    logic                           key_ready_q;

    // H^2 straight from the key input.
    gf128_mult u_square
    (
        .i_data_x (i_h_key),
        .i_data_y (i_h_key),
        .o_data_z (h_sq)
    );

    assign pow_d[0] = i_h_key;
    assign pow_d[1] = h_sq;

    // Both powers captured on the load edge.
    always_ff @(posedge i_clock)
    begin
        if (i_key_load)
        begin
            for (int k = 0; k < ghash_pkg::N_POWERS; k++)
            begin
                pow_q[k] <= pow_d[k];
            end
        end
    end

    // Ready from the cycle after the first load.
    // A reload keeps it high.
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            key_ready_q <= 1'b0;
        else if (i_key_load)
            key_ready_q <= 1'b1;
    end

    assign o_powers    = '{h1: pow_q[0], h2: pow_q[1]};
    assign o_key_ready = key_ready_q;

    // Loads come as single-cycle pulses.
    a_key_load_pulse : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_key_load |=> !i_key_load
    );

endmodule

//--- design/ghash_pair_stage.sv
`timescale 1ns/1ns

module ghash_pair_stage
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  ghash_pkg::ghash_block_t i_blk,
    input  logic                    i_blk_valid,
    output logic                    o_blk_ready,
    output ghash_pkg::ghash_pair_t  o_pair,
    output logic                    o_pair_valid,
    input  logic                    i_pair_ready
);

    // First block waiting for its partner.
    logic [ghash_pkg::NB_BLOCK-1:0] hold_q;
    logic                           hold_valid_q;
    // Output pair register.
    ghash_pkg::ghash_pair_t         pair_q;
    logic                           pair_valid_q;
    ghash_pkg::ghash_pair_t         pair_d;
    // Set on the first edge out of reset.
    logic                           init_done_q;
    logic                           blk_fire;
    logic                           pair_emit;

    // Accept while the pair register is free or draining.
    assign o_blk_ready = init_done_q && (!pair_valid_q || i_pair_ready);
    assign blk_fire    = i_blk_valid && o_blk_ready;

    // A second block completes a pair.
    // A lone last block goes out as a single.
    assign pair_emit = blk_fire && (hold_valid_q || i_blk.last);

    always_comb
    begin
        pair_d.first  = hold_valid_q ? hold_q : i_blk.data;
        pair_d.second = hold_valid_q ? i_blk.data : '0;
        pair_d.single = !hold_valid_q;
        pair_d.last   = i_blk.last;
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            init_done_q  <= 1'b0;
            hold_valid_q <= 1'b0;
            pair_valid_q <= 1'b0;
        end
        else
        begin
            init_done_q <= 1'b1;
            // Hold only an odd block that is not the last.
            if (blk_fire)
                hold_valid_q <= !hold_valid_q && !i_blk.last;
            if (pair_emit)
                pair_valid_q <= 1'b1;
            else if (i_pair_ready)
                pair_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (blk_fire && !hold_valid_q)
            hold_q <= i_blk.data;
        if (pair_emit)
            pair_q <= pair_d;
    end

    assign o_pair       = pair_q;
    assign o_pair_valid = pair_valid_q;

    // Stalled pair must not change.
    a_pair_stable : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (o_pair_valid && !i_pair_ready) |=> (o_pair_valid && $stable(o_pair))
    );

endmodule

//--- design/ghash_accumulator.sv
`timescale 1ns/1ns

module ghash_accumulator
(
    input  logic                          i_clock,
    input  logic                          i_rst_n,
    input  ghash_pkg::ghash_pair_t        i_pair,
    input  logic                          i_pair_valid,
    output logic                          o_pair_ready,
    input  ghash_pkg::ghash_powers_t      i_powers,
    input  logic                          i_key_ready,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_tag,
    output logic                          o_tag_valid,
    input  logic                          i_tag_ready
);

    // Running hash, also the tag once complete.
    logic [ghash_pkg::NB_BLOCK-1:0] hash_q;
    logic [ghash_pkg::NB_BLOCK-1:0] hash_d;
    logic                           tag_valid_q;
    // Operands and products of the two multipliers.
    logic [ghash_pkg::NB_BLOCK-1:0] hi_x;
    logic [ghash_pkg::NB_BLOCK-1:0] hi_y;
    logic [ghash_pkg::NB_BLOCK-1:0] prod_hi;
    logic [ghash_pkg::NB_BLOCK-1:0] prod_lo;
    logic                           pair_fire;
    logic                           tag_fire;

    // Stall with no key or while a tag waits.
    assign o_pair_ready = i_key_ready && !tag_valid_q;
    assign pair_fire    = i_pair_valid && o_pair_ready;
    assign tag_fire     = tag_valid_q && i_tag_ready;

    // (Y ^ A) * H^2, or * H for a lone block.
    assign hi_x = hash_q ^ i_pair.first;
    assign hi_y = i_pair.single ? i_powers.h1 : i_powers.h2;

    gf128_mult u_mult_hi
    (
        .i_data_x (hi_x),
        .i_data_y (hi_y),
        .o_data_z (prod_hi)
    );

    // B * H.
    gf128_mult u_mult_lo
    (
        .i_data_x (i_pair.second),
        .i_data_y (i_powers.h1),
        .o_data_z (prod_lo)
    );

    // Second product dropped for a single.
    assign hash_d = i_pair.single ? prod_hi : (prod_hi ^ prod_lo);

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            hash_q      <= '0;
            tag_valid_q <= 1'b0;
        end
        else if (pair_fire)
        begin
            hash_q      <= hash_d;
            tag_valid_q <= i_pair.last;
        end
        else if (tag_fire)
        begin
            // Next message starts from zero.
            hash_q      <= '0;
            tag_valid_q <= 1'b0;
        end
    end

    assign o_tag       = hash_q;
    assign o_tag_valid = tag_valid_q;

    // Pending tag is never folded with a new pair.
    // It either stays put or is taken and cleared.
    a_no_pair_on_tag : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_tag_valid |=> (o_tag_valid && $stable(o_tag)) || (!o_tag_valid && o_tag == '0)
    );

    // Tag held steady under back-pressure.
    a_tag_stable : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (o_tag_valid && !i_tag_ready) |=> (o_tag_valid && $stable(o_tag))
    );

endmodule

//--- design/ghash_top.sv
`timescale 1ns/1ns

module ghash_top
(
    input  logic                          i_clock,
    input  logic                          i_rst_n,
    input  logic                          i_key_load,
    input  logic [ghash_pkg::NB_BLOCK-1:0] i_h_key,
    output logic                          o_key_ready,
    input  ghash_pkg::ghash_block_t       i_blk,
    input  logic                          i_blk_valid,
    output logic                          o_blk_ready,
    output logic [ghash_pkg::NB_BLOCK-1:0] o_tag,
    output logic                          o_tag_valid,
    input  logic                          i_tag_ready
);

    // Pair stage to accumulator.
    ghash_pkg::ghash_pair_t   pair;
    logic                     pair_valid;
    logic                     pair_ready;
    // Power table to accumulator.
    ghash_pkg::ghash_powers_t powers;
    logic                     key_ready;

    h_key_power_table u_h_key_power_table
    (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_key_load  (i_key_load),
        .i_h_key     (i_h_key),
        .o_powers    (powers),
        .o_key_ready (key_ready)
    );

    ghash_pair_stage u_ghash_pair_stage
    (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_blk        (i_blk),
        .i_blk_valid  (i_blk_valid),
        .o_blk_ready  (o_blk_ready),
        .o_pair       (pair),
        .o_pair_valid (pair_valid),
        .i_pair_ready (pair_ready)
    );

    ghash_accumulator u_ghash_accumulator
    (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_pair       (pair),
        .i_pair_valid (pair_valid),
        .o_pair_ready (pair_ready),
        .i_powers     (powers),
        .i_key_ready  (key_ready),
        .o_tag        (o_tag),
        .o_tag_valid  (o_tag_valid),
        .i_tag_ready  (i_tag_ready)
    );

    assign o_key_ready = key_ready;

endmodule

//--- verif/ghash_tb.sv
`timescale 1ns/1ns

module ghash_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                           clock;
    logic                           rst_n;
    logic                           key_load;
    logic [ghash_pkg::NB_BLOCK-1:0] h_key;
    logic                           key_ready;
    ghash_pkg::ghash_block_t        blk;
    logic                           blk_valid;
    logic                           blk_ready;
    logic [ghash_pkg::NB_BLOCK-1:0] tag;
    logic                           tag_valid;
    logic                           tag_ready;

    // Expected tags with their test names, in message order.
    logic [ghash_pkg::NB_BLOCK-1:0] exp_q[$];
    string                          name_q[$];
    // Tags taken from the DUT output.
    logic [ghash_pkg::NB_BLOCK-1:0] got_q[$];
    int                             n_sent;
    int                             n_checked;
    logic [31:0]                    lcg_state = 32'd40339;
    // Random tag stalls and input gaps.
    logic                           stall_en;
    int                             stretch;
    logic [ghash_pkg::NB_BLOCK-1:0] cur_key;

    ghash_top u_ghash_top
    (
        .i_clock     (clock),
        .i_rst_n     (rst_n),
        .i_key_load  (key_load),
        .i_h_key     (h_key),
        .o_key_ready (key_ready),
        .i_blk       (blk),
        .i_blk_valid (blk_valid),
        .o_blk_ready (blk_ready),
        .o_tag       (tag),
        .o_tag_valid (tag_valid),
        .i_tag_ready (tag_ready)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #10 clock = ~clock;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [ghash_pkg::NB_BLOCK-1:0] rand_block();
        return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    endfunction

    // Schoolbook carry-less product, then reduction.
    // Coefficient of x^i sits at bit 127-i of a block.
    function automatic logic [ghash_pkg::NB_BLOCK-1:0] gf_mult_ref(
        input logic [ghash_pkg::NB_BLOCK-1:0] a,
        input logic [ghash_pkg::NB_BLOCK-1:0] b
    );
        logic [254:0]                   p;
        logic [ghash_pkg::NB_BLOCK-1:0] z;
        p = '0;
        for (int i = 0; i < 128; i++)
        begin
            for (int j = 0; j < 128; j++)
            begin
                p[i+j] = p[i+j] ^ (a[127-i] & b[127-j]);
            end
        end
        // Fold x^d down with x^128 = x^7 + x^2 + x + 1.
        for (int d = 254; d >= 128; d--)
        begin
            if (p[d])
            begin
                p[d]     = 1'b0;
                p[d-121] = ~p[d-121];
                p[d-126] = ~p[d-126];
                p[d-127] = ~p[d-127];
                p[d-128] = ~p[d-128];
            end
        end
        for (int i = 0; i < 128; i++)
        begin
            z[127-i] = p[i];
        end
        return z;
    endfunction

    // One block per step, starting from zero.
    function automatic logic [ghash_pkg::NB_BLOCK-1:0] ghash_ref(
        input logic [ghash_pkg::NB_BLOCK-1:0] h,
        input logic [ghash_pkg::NB_BLOCK-1:0] blks[$]
    );
        logic [ghash_pkg::NB_BLOCK-1:0] y;
        y = '0;
        foreach (blks[i])
        begin
            y = gf_mult_ref(y ^ blks[i], h);
        end
        return y;
    endfunction

    task automatic fail_with(input string what);
        $display("ERROR: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(
        input string                          test,
        input logic [ghash_pkg::NB_BLOCK-1:0] expected,
        input logic [ghash_pkg::NB_BLOCK-1:0] actual
    );
        if (expected !== actual)
        begin
            $display("MISMATCH test=%s expected=%h actual=%h", test, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Tag mismatch in %s", test);
        end
    endtask

    // Next drive point, just after the rising edge.
    task automatic tick();
        @(posedge clock);
        #2;
    endtask

    task automatic load_key(input logic [ghash_pkg::NB_BLOCK-1:0] key);
        int cnt;
        cnt      = 0;
        key_load = 1'b1;
        h_key    = key;
        cur_key  = key;
        tick();
        key_load = 1'b0;
        while (!key_ready)
        begin
            cnt++;
            if (cnt > TIMEOUT_CYCLES)
                fail_with("Timed out waiting for o_key_ready after a key load.");
            tick();
        end
    endtask

    // Valid held until the edge that sees ready.
    task automatic send_block(input logic [ghash_pkg::NB_BLOCK-1:0] data_in, input logic is_last);
        int cnt;
        cnt       = 0;
        blk       = '{data: data_in, last: is_last};
        blk_valid = 1'b1;
        @(negedge clock);
        while (!blk_ready)
        begin
            cnt++;
            if (cnt > TIMEOUT_CYCLES)
                fail_with("Timed out waiting for o_blk_ready.");
            @(negedge clock);
        end
        tick();
        blk_valid = 1'b0;
    endtask

    task automatic send_blocks(input string name, input logic [ghash_pkg::NB_BLOCK-1:0] blks[$]);
        exp_q.push_back(ghash_ref(cur_key, blks));
        name_q.push_back(name);
        n_sent++;
        foreach (blks[i])
        begin
            // Random input gaps under stall mode.
            if (stall_en)
                repeat (lcg_next() % 32'd4) tick();
            send_block(blks[i], i == blks.size() - 1);
        end
    endtask

    task automatic send_message(input string name, input int nblk);
        logic [ghash_pkg::NB_BLOCK-1:0] blks[$];
        for (int i = 0; i < nblk; i++)
        begin
            blks.push_back(rand_block());
        end
        send_blocks(name, blks);
    endtask

    // Wait until every expected tag has been compared.
    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0)
        begin
            cnt++;
            if (cnt > TIMEOUT_CYCLES)
                fail_with("Timed out waiting for outstanding tags to drain.");
            tick();
        end
    endtask

    // Tag ready, random high and low stretches in stall mode.
    initial
    begin
        logic [31:0] r;
        stretch = 0;
        forever
        begin
            tick();
            if (!stall_en)
                tag_ready = 1'b1;
            else if (stretch == 0)
            begin
                r         = lcg_next();
                tag_ready = r[4];
                stretch   = int'(r[10:8]);
            end
            else
                stretch--;
        end
    end

    // Monitor. Values at the falling edge hold through the next rising edge.
    initial
    begin
        forever
        begin
            @(negedge clock);
            if (rst_n && tag_valid && tag_ready)
                got_q.push_back(tag);
        end
    end

    // Comparison, strictly in message order.
    initial
    begin
        int                             idle;
        string                          name;
        logic [ghash_pkg::NB_BLOCK-1:0] expected;
        logic [ghash_pkg::NB_BLOCK-1:0] actual;
        idle = 0;
        forever
        begin
            @(negedge clock);
            #1;
            if (got_q.size() > 0)
            begin
                if (exp_q.size() == 0)
                    fail_with("A tag arrived with no message outstanding.");
                else
                begin
                    name     = name_q.pop_front();
                    expected = exp_q.pop_front();
                    actual   = got_q.pop_front();
                    check_value(name, expected, actual);
                    n_checked++;
                    idle = 0;
                end
            end
            else if (exp_q.size() > 0)
            begin
                idle++;
                if (idle > TIMEOUT_CYCLES)
                    fail_with("Timed out waiting for o_tag_valid.");
            end
            else
                idle = 0;
        end
    end

    initial
    begin
        logic [ghash_pkg::NB_BLOCK-1:0] vec[$];
        logic [ghash_pkg::NB_BLOCK-1:0] flags;
        rst_n     = 1'b0;
        key_load  = 1'b0;
        h_key     = '0;
        blk       = '0;
        blk_valid = 1'b0;
        tag_ready = 1'b0;
        stall_en  = 1'b0;
        cur_key   = '0;
        n_sent    = 0;
        n_checked = 0;
        repeat (10) @(posedge clock);
        #2;
        // Key ready, block ready and tag valid all low in reset.
        flags      = '0;
        flags[2:0] = {key_ready, blk_ready, tag_valid};
        check_value("reset_outputs", '0, flags);
        rst_n = 1'b1;
        tick();

        // GCM test case 2, ciphertext and length block.
        load_key(128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        vec.push_back(128'h0388dace60b6a392f328c2b971b2fe78);
        vec.push_back(128'h00000000000000000000000000000080);
        check_value("gcm_case2_model", 128'hf38cbb1ad69223dcc3457ae5b6b0f885,
                    ghash_ref(cur_key, vec));
        send_blocks("gcm_case2", vec);
        drain();

        // Odd lengths end with a single step.
        load_key(rand_block());
        send_message("length_1", 1);
        send_message("length_2", 2);
        send_message("length_3", 3);
        send_message("length_4", 4);
        send_message("length_7", 7);
        drain();

        stall_en = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            send_message($sformatf("backpressure_%0d", i), 1 + int'(lcg_next() % 32'd7));
        end
        drain();
        stall_en = 1'b0;

        // No idle cycles between messages.
        for (int i = 0; i < 6; i++)
        begin
            send_message($sformatf("back_to_back_%0d", i), 1 + int'(lcg_next() % 32'd6));
        end
        drain();

        load_key(rand_block());
        send_message("reload_a", 5);
        send_message("reload_b", 2);
        drain();

        // Room for a stray extra tag to show up.
        repeat (20) tick();
        if (n_checked == n_sent && got_q.size() == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("ERROR: %0d tags checked, %0d messages sent.", n_checked, n_sent);
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/ghash_pkg.sv
design/gf128_mult.sv
h_key_power_table/h_key_power_table.sv
design/ghash_pair_stage.sv
design/ghash_accumulator.sv
design/ghash_top.sv
verif/ghash_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the GHASH testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ghash_sim
LOG=sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module ghash_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -q "^SIMULATION PASSED$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

echo "Run finished, log in $LOG"
exit 0
